/* all.f */
+incdir+test
common/mipsPkg.sv
common/fwdBusIf.sv
source/fetchStage.sv
source/decode/regFile.sv
source/decode/decodeStage.sv
source/execStage.sv
source/memWbStage.sv
source/mipsCore.sv
test/tbMipsCore.sv

/* common/fwdBusIf.sv */
interface fwdBusIf;

  // Results of the two older stages for forwarding into execute
  // and for the register file write from writeback

  mipsPkg::regIdxT meDst;    // Dest of instruction in memory stage
  mipsPkg::wordT   meResult; // Its ALU result, or address for lw/sw
  mipsPkg::regIdxT wbDst;    // Dest of instruction in writeback
  mipsPkg::wordT   wbData;   // Final value, load data already selected

  modport exSide (
    output meDst, meResult
  );

  modport wbSide (
    output wbDst, wbData
  );

  modport fwdUse (
    input meDst, meResult, wbDst, wbData
  );

  modport regWrite (
    input wbDst, wbData
  );

endinterface

/* common/mipsPkg.sv */
package mipsPkg;

  typedef logic [31:0] wordT;   // Data word and byte address
  typedef logic [4:0]  regIdxT; // Register number

  localparam wordT   PcStride  = 32'd4;   // One instruction word
  localparam regIdxT ZeroReg   = 5'd0;    // Hardwired zero, also "no write"
  localparam logic [3:0] ByteEnAll = 4'b1111; // Full word store
  localparam wordT   ResetPc   = 32'h0000_0000;

  // Major opcodes, instr[31:26]
  typedef enum logic [5:0] {
    opSpecial = 6'h00, // R format, see functE
    opBeq     = 6'h04,
    opBne     = 6'h05,
    opAddi    = 6'h08,
    opLw      = 6'h23,
    opSw      = 6'h2b
  } opcodeE;

  // R format function codes, instr[5:0]
  typedef enum logic [5:0] {
    fnSllv = 6'h04,
    fnSrlv = 6'h06,
    fnAdd  = 6'h20
  } functE;

  typedef enum logic [1:0] {
    aluAdd,  // Also address calc for lw/sw
    aluSllv, // op1 << op2[4:0]
    aluSrlv  // op1 >> op2[4:0], logical
  } aluOpE;

  // One decoded instruction, all zero is a null instruction
  typedef struct packed {
    aluOpE  aluOp;
    logic   isLoad;
    logic   isStore;
    logic   isBranch; // beq or bne
    logic   isBne;    // Qualifies isBranch
    logic   useImm;   // Second ALU operand is imm
    regIdxT rs;
    regIdxT rt;
    regIdxT dst;      // ZeroReg when nothing is written
    wordT   imm;      // Sign extended
    wordT   pc4;      // Address of next instruction
    wordT   target;   // Branch target, pc4 + imm*4
  } decodedT;

endpackage

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tbMipsCore -o simv

out=$(./obj_dir/simv || true)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1

/* source/decode/decodeStage.sv */
module decodeStage (
  input  logic             CLK,
  input  logic             RST_X,
  input  logic             STALL,
  input  mipsPkg::wordT    instr,
  input  mipsPkg::wordT    pc4,
  input  logic             flush,     // Taken branch in execute
  fwdBusIf.regWrite        wr,        // Writeback port of register file
  output logic             interlock,
  output mipsPkg::decodedT decoded,   // ID/EX register
  output mipsPkg::wordT    rsVal,     // Registered operands
  output mipsPkg::wordT    rtVal
);

  mipsPkg::decodedT dec;     // Decode of current instr
  mipsPkg::opcodeE  opcode;
  mipsPkg::functE   funct;
  mipsPkg::wordT    rsRead;  // Register file outputs
  mipsPkg::wordT    rtRead;
  logic             usesRt;  // rt is a source, not a dest

  assign opcode = mipsPkg::opcodeE'(instr[31:26]);
  assign funct  = mipsPkg::functE'(instr[5:0]);

  always_comb begin
    dec        = '0;
    dec.rs     = instr[25:21];
    dec.rt     = instr[20:16];
    dec.imm    = {{16{instr[15]}}, instr[15:0]};
    dec.pc4    = pc4;
    dec.target = pc4 + {dec.imm[29:0], 2'b00};
    usesRt     = 1'b0;
    case (opcode)
      mipsPkg::opSpecial: begin
        usesRt = 1'b1;
        case (funct)
          mipsPkg::fnAdd:  dec.dst = instr[15:11];
          mipsPkg::fnSllv: begin
            dec.dst   = instr[15:11];
            dec.aluOp = mipsPkg::aluSllv;
          end
          mipsPkg::fnSrlv: begin
            dec.dst   = instr[15:11];
            dec.aluOp = mipsPkg::aluSrlv;
          end
          default: ;                      // Unknown, stays null
        endcase
      end
      mipsPkg::opAddi: begin
        dec.useImm = 1'b1;
        dec.dst    = instr[20:16];
      end
      mipsPkg::opLw: begin
        dec.isLoad = 1'b1;
        dec.useImm = 1'b1;                // Address = rs + imm
        dec.dst    = instr[20:16];
      end
      mipsPkg::opSw: begin
        dec.isStore = 1'b1;
        dec.useImm  = 1'b1;
        usesRt      = 1'b1;               // Store data
      end
      mipsPkg::opBeq: begin
        dec.isBranch = 1'b1;
        usesRt       = 1'b1;
      end
      mipsPkg::opBne: begin
        dec.isBranch = 1'b1;
        dec.isBne    = 1'b1;
        usesRt       = 1'b1;
      end
      default: ;
    endcase
  end

  // Load in execute whose data is needed right now
  assign interlock = decoded.isLoad && decoded.dst != mipsPkg::ZeroReg &&
                     (dec.rs == decoded.dst || (usesRt && dec.rt == decoded.dst));

  regFile regs (
    .CLK    (CLK),
    .STALL  (STALL),
    .rsIdx  (dec.rs),
    .rtIdx  (dec.rt),
    .wrIdx  (wr.wbDst),
    .wrData (wr.wbData),
    .rsVal  (rsRead),
    .rtVal  (rtRead)
  );

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      decoded <= '0;
    end else if (!STALL) begin
      decoded <= (interlock || flush) ? '0 : dec; // Bubble or squash
    end
  end

  always_ff @(posedge CLK) begin
    if (!STALL) begin
      rsVal <= rsRead;
      rtVal <= rtRead;
    end
  end

endmodule

/* source/decode/regFile.sv */
module regFile (
  input  logic            CLK,
  input  logic            STALL,   // No write while frozen
  input  mipsPkg::regIdxT rsIdx,
  input  mipsPkg::regIdxT rtIdx,
  input  mipsPkg::regIdxT wrIdx,
  input  mipsPkg::wordT   wrData,
  output mipsPkg::wordT   rsVal,
  output mipsPkg::wordT   rtVal
);

  mipsPkg::wordT regs [32];  // 32 x 32 storage
  logic          wrEn;

  assign wrEn = !STALL && wrIdx != mipsPkg::ZeroReg;

  always_ff @(posedge CLK) begin
    if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  // Same-cycle write passes through to the reader
  always_comb begin
    if (rsIdx == mipsPkg::ZeroReg) rsVal = '0;
    else if (wrEn && wrIdx == rsIdx) rsVal = wrData;
    else rsVal = regs[rsIdx];
  end

  always_comb begin
    if (rtIdx == mipsPkg::ZeroReg) rtVal = '0;
    else if (wrEn && wrIdx == rtIdx) rtVal = wrData;
    else rtVal = regs[rtIdx];
  end

endmodule

/* source/execStage.sv */
module execStage (
  input  logic             CLK,
  input  logic             RST_X,
  input  logic             STALL,
  input  mipsPkg::decodedT decoded,     // ID/EX register
  input  mipsPkg::wordT    rsVal,
  input  mipsPkg::wordT    rtVal,
  fwdBusIf.exSide          ex,          // EX/MEM result out
  fwdBusIf.fwdUse          fwd,         // Older results in
  output logic             redirect,
  output mipsPkg::wordT    redirectPc,
  output logic             flush,
  output logic             meIsLoad,
  output logic             meIsStore,
  output mipsPkg::wordT    meStoreData
);

  mipsPkg::wordT   rsFwd;       // Operands after forwarding
  mipsPkg::wordT   rtFwd;
  mipsPkg::wordT   op2;         // rt or imm
  mipsPkg::wordT   aluResult;
  logic            taken;
  mipsPkg::regIdxT meDstQ;      // EX/MEM register
  mipsPkg::wordT   meResultQ;

  // Youngest producer wins, register 0 never forwards
  function automatic mipsPkg::wordT fwdSel(
    input mipsPkg::regIdxT src,
    input mipsPkg::wordT   regVal,
    input mipsPkg::regIdxT meDst,
    input mipsPkg::wordT   meRes,
    input mipsPkg::regIdxT wbDst,
    input mipsPkg::wordT   wbVal
  );
    if (src != mipsPkg::ZeroReg && src == meDst) return meRes;
    if (src != mipsPkg::ZeroReg && src == wbDst) return wbVal;
    return regVal;
  endfunction

  assign rsFwd = fwdSel(decoded.rs, rsVal, fwd.meDst, fwd.meResult, fwd.wbDst, fwd.wbData);
  assign rtFwd = fwdSel(decoded.rt, rtVal, fwd.meDst, fwd.meResult, fwd.wbDst, fwd.wbData);
  assign op2   = decoded.useImm ? decoded.imm : rtFwd;

  always_comb begin
    case (decoded.aluOp)
      mipsPkg::aluSllv: aluResult = rsFwd << op2[4:0];
      mipsPkg::aluSrlv: aluResult = rsFwd >> op2[4:0];
      default:          aluResult = rsFwd + op2;
    endcase
  end

  // beq on equal, bne on different
  assign taken      = decoded.isBranch && (decoded.isBne ? rsFwd != rtFwd : rsFwd == rtFwd);
  assign redirect   = taken;
  assign flush      = taken;   // Squashes decode's instruction
  assign redirectPc = decoded.target;

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      meDstQ    <= mipsPkg::ZeroReg;
      meIsLoad  <= 1'b0;
      meIsStore <= 1'b0;
    end else if (!STALL) begin
      meDstQ    <= decoded.dst;
      meIsLoad  <= decoded.isLoad;
      meIsStore <= decoded.isStore;
    end
  end

  always_ff @(posedge CLK) begin
    if (!STALL) begin
      meResultQ   <= aluResult;   // Sum, shift or memory address
      meStoreData <= rtFwd;
    end
  end

  assign ex.meDst    = meDstQ;
  assign ex.meResult = meResultQ;

  // Decode must null the ID/EX slot behind a taken branch
  assert property (@(posedge CLK) disable iff (!RST_X) redirect && !STALL |=> !redirect)
    else $error("redirect held past one cycle");

endmodule

/* source/fetchStage.sv */
module fetchStage (
  input  logic          CLK,
  input  logic          RST_X,
  input  logic          STALL,
  input  logic          interlock,  // Decode holds for a load-use bubble
  input  logic          redirect,   // Taken branch, jump to redirectPc
  input  mipsPkg::wordT redirectPc,
  input  mipsPkg::wordT iIn,
  output mipsPkg::wordT iAddr,
  output mipsPkg::wordT instr,      // To decode
  output mipsPkg::wordT pc4
);

  mipsPkg::wordT pc;        // Address presented this cycle
  mipsPkg::wordT pc4Q;      // pc + 4 of the word now in IF/ID
  mipsPkg::wordT heldWord;  // iIn captured on first frozen cycle
  logic          validQ;    // IF/ID word is real, not squashed
  logic          heldQ;     // heldWord replaces iIn
  logic          hold;

  assign hold  = STALL || interlock;
  assign iAddr = pc;
  assign pc4   = pc4Q;

  // Memory keeps reading pc while frozen, so the older word is kept aside
  assign instr = !validQ ? '0 : (heldQ ? heldWord : iIn); // Zero decodes as null

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      pc     <= mipsPkg::ResetPc;
      validQ <= 1'b0;            // iIn not yet from a real fetch
      heldQ  <= 1'b0;
    end else if (!hold) begin
      pc     <= redirect ? redirectPc : pc + mipsPkg::PcStride;
      validQ <= !redirect;       // Squash the word in flight
      heldQ  <= 1'b0;
    end else if (!heldQ) begin
      heldQ  <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!hold) begin
      pc4Q <= pc + mipsPkg::PcStride;
    end
    if (hold && !heldQ) begin
      heldWord <= iIn;           // Last valid word before freeze
    end
  end

  // Targets come from decode as pc4 + imm*4
  assert property (@(posedge CLK) disable iff (!RST_X) iAddr[1:0] == 2'b00)
    else $error("fetch address not word aligned");

endmodule

/* source/memWbStage.sv */
module memWbStage (
  input  logic          CLK,
  input  logic          RST_X,
  input  logic          STALL,
  input  logic          meIsLoad,
  input  logic          meIsStore,
  input  mipsPkg::wordT meStoreData,
  input  mipsPkg::wordT dIn,
  fwdBusIf.wbSide       wb,         // MEM/WB result out
  fwdBusIf.fwdUse       fwd,        // EX/MEM dst and result in
  output mipsPkg::wordT dAddr,
  output mipsPkg::wordT dOut,
  output logic          dOe,
  output logic [3:0]    dWe
);

  mipsPkg::regIdxT wbDstQ;     // MEM/WB register
  logic            wbLoadQ;
  mipsPkg::wordT   wbResultQ;
  mipsPkg::wordT   dInHeld;    // Load data kept over a freeze
  logic            heldQ;      // Previous cycle was frozen

  assign dAddr = fwd.meResult;
  assign dOut  = meStoreData;
  assign dOe   = meIsLoad;
  assign dWe   = (meIsStore && !STALL) ? mipsPkg::ByteEnAll : 4'b0000; // One write per sw

  always_ff @(posedge CLK) begin
    if (!RST_X) begin
      wbDstQ  <= mipsPkg::ZeroReg;
      wbLoadQ <= 1'b0;
      heldQ   <= 1'b0;
    end else begin
      heldQ <= STALL;
      if (!STALL) begin
        wbDstQ  <= fwd.meDst;
        wbLoadQ <= meIsLoad;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!STALL) begin
      wbResultQ <= fwd.meResult;
    end
    if (STALL && !heldQ) begin
      dInHeld <= dIn;          // dIn moves on to the next address
    end
  end

  assign wb.wbDst  = wbDstQ;
  assign wb.wbData = wbLoadQ ? (heldQ ? dInHeld : dIn) : wbResultQ;

  // Decode never marks one instruction as both load and store
  assert property (@(posedge CLK) disable iff (!RST_X) !(dOe && dWe != 4'b0000))
    else $error("data port read and write at once");

endmodule

/* source/mipsCore.sv */
module mipsCore (
  input  logic          CLK,
  input  logic          RST_X,
  input  logic          STALL,   // Freezes every stage
  output mipsPkg::wordT iAddr,
  input  mipsPkg::wordT iIn,     // One cycle after iAddr
  output mipsPkg::wordT dAddr,
  input  mipsPkg::wordT dIn,     // One cycle after dAddr with dOe
  output mipsPkg::wordT dOut,
  output logic          dOe,
  output logic [3:0]    dWe
);

  mipsPkg::wordT    instr;       // IF/ID word
  mipsPkg::wordT    pc4;         // IF/ID pc + 4
  logic             interlock;   // Load-use bubble request
  logic             redirect;    // Taken branch in execute
  mipsPkg::wordT    redirectPc;
  logic             flush;       // Same as redirect
  mipsPkg::decodedT decoded;     // ID/EX register
  mipsPkg::wordT    rsVal;
  mipsPkg::wordT    rtVal;
  logic             meIsLoad;
  logic             meIsStore;
  mipsPkg::wordT    meStoreData;

  fwdBusIf fwd ();

  fetchStage fetch (
    .CLK        (CLK),
    .RST_X      (RST_X),
    .STALL      (STALL),
    .interlock  (interlock),
    .redirect   (redirect),
    .redirectPc (redirectPc),
    .iIn        (iIn),
    .iAddr      (iAddr),
    .instr      (instr),
    .pc4        (pc4)
  );

  decodeStage decode (
    .CLK       (CLK),
    .RST_X     (RST_X),
    .STALL     (STALL),
    .instr     (instr),
    .pc4       (pc4),
    .flush     (flush),
    .wr        (fwd.regWrite),
    .interlock (interlock),
    .decoded   (decoded),
    .rsVal     (rsVal),
    .rtVal     (rtVal)
  );

  execStage exec (
    .CLK         (CLK),
    .RST_X       (RST_X),
    .STALL       (STALL),
    .decoded     (decoded),
    .rsVal       (rsVal),
    .rtVal       (rtVal),
    .ex          (fwd.exSide),
    .fwd         (fwd.fwdUse),
    .redirect    (redirect),
    .redirectPc  (redirectPc),
    .flush       (flush),
    .meIsLoad    (meIsLoad),
    .meIsStore   (meIsStore),
    .meStoreData (meStoreData)
  );

  memWbStage memWb (
    .CLK         (CLK),
    .RST_X       (RST_X),
    .STALL       (STALL),
    .meIsLoad    (meIsLoad),
    .meIsStore   (meIsStore),
    .meStoreData (meStoreData),
    .dIn         (dIn),
    .wb          (fwd.wbSide),
    .fwd         (fwd.fwdUse),
    .dAddr       (dAddr),
    .dOut        (dOut),
    .dOe         (dOe),
    .dWe         (dWe)
  );

endmodule

/* test/golden_program.txt */
// @00 program words, one per line, ffffffff ends it
// @40 initial data as byte address and word, @80 expected stores as address and data
@00
20010005 // addi r1,r0,5
20220007 // addi r2,r1,7     r2=12
00411820 // add r3,r2,r1     r3=17
00632020 // add r4,r3,r3     r4=34
AC040000 // sw r4,0(r0)
AC030004 // sw r3,4(r0)
20050003 // addi r5,r0,3
00253004 // sllv r6,r1,r5    r6=5<<3
2008FFF0 // addi r8,r0,-16
01053806 // srlv r7,r8,r5    logical
AC060008 // sw r6,8(r0)
AC07000C // sw r7,12(r0)
8C090040 // lw r9,0x40(r0)
01215020 // add r10,r9,r1    load-use
AC0A0010 // sw r10,16(r0)
8C0B0044 // lw r11,0x44(r0)
AC0B0014 // sw r11,20(r0)    load-use on store data
10220002 // beq r1,r2 not taken
AC010018 // sw r1,24(r0)
10630002 // beq r3,r3 taken
AC02001C // sw r2,28(r0)     skipped
AC020020 // sw r2,32(r0)     skipped
14210001 // bne r1,r1 not taken
AC020024 // sw r2,36(r0)
14220001 // bne r1,r2 taken
AC010028 // sw r1,40(r0)     skipped
AC09002C // sw r9,44(r0)
1000FFFF // beq r0,r0 self loop
ffffffff
@40
00000040 00001000
00000044 00000200
ffffffff
@80
00000000 00000022
00000004 00000011
00000008 00000028
0000000C 1FFFFFFE
00000010 00001005
00000014 00000200
00000018 00000005
00000024 0000000C
0000002C 00001000
ffffffff

/* test/tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errorCount = 0;  // Mismatches seen so far
int checkCount = 0;  // Compares done so far

// Address of the idx-th store on the data port
task automatic checkStoreAddr(input mipsPkg::wordT got, input mipsPkg::wordT exp,
                              input int idx);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("[FAIL] %0t store %0d address 0x%08h, expected 0x%08h", $time, idx, got, exp);
  end
endtask

// Data of the idx-th store
task automatic checkStoreData(input mipsPkg::wordT got, input mipsPkg::wordT exp,
                              input int idx);
  checkCount++;
  if (got !== exp) begin
    errorCount++;
    $display("[FAIL] %0t store %0d data 0x%08h, expected 0x%08h", $time, idx, got, exp);
  end
endtask

task automatic checkStoreCount(input int got, input int exp);
  checkCount++;
  if (got != exp) begin
    errorCount++;
    $display("[FAIL] %0t store count %0d, expected %0d", $time, got, exp);
  end
endtask

// Port levels right after reset
task automatic checkIdlePorts(input mipsPkg::wordT addr, input logic oe,
                              input logic [3:0] we);
  checkCount++;
  if (addr !== mipsPkg::ResetPc || oe !== 1'b0 || we !== 4'b0000) begin
    errorCount++;
    $display("[FAIL] %0t after reset iAddr 0x%08h dOe %b dWe %b, expected 0x%08h 0 0000",
             $time, addr, oe, we, mipsPkg::ResetPc);
  end
endtask

`endif

/* test/tbMipsCore.sv */
module tbMipsCore;

  localparam int GoldDepth    = 256;              // Words in the golden image
  localparam int ProgBase     = 0;                // Program section
  localparam int DataBase     = 64;               // Initial data pairs
  localparam int StoreBase    = 128;              // Expected store pairs
  localparam int MemWords     = 1024;             // 4 KB per memory
  localparam int SettleCycles = 30;               // Watch for stray stores
  localparam mipsPkg::wordT Sentinel = 32'hffff_ffff;
  localparam logic [31:0]   Seed     = 32'h61e44f12;

  logic             CLK;
  logic             RST_X;
  logic             STALL;
  mipsPkg::wordT    iAddr;
  mipsPkg::wordT    iIn;
  mipsPkg::wordT    dAddr;
  mipsPkg::wordT    dIn;
  mipsPkg::wordT    dOut;
  logic             dOe;
  logic [3:0]       dWe;

  mipsPkg::wordT    golden [GoldDepth];  // Raw file image
  mipsPkg::wordT    imem [MemWords];
  mipsPkg::wordT    dmem [MemWords];
  mipsPkg::wordT    expAddr [$];         // Expected store sequence
  mipsPkg::wordT    expData [$];
  mipsPkg::wordT    iAddrQ;              // Fetch address taken at the rising edge
  mipsPkg::wordT    dAddrQ;              // Load address taken at the rising edge
  logic             dReadQ;              // Load read pending
  int               progLen;
  int               storeCount;          // Stores seen on the port
  int               cycles;
  int               cycleLimit;
  logic             running;             // Reset released

  `include "tbChecks.svh"

  mipsCore i_mipsCore (
    .CLK   (CLK),
    .RST_X (RST_X),
    .STALL (STALL),
    .iAddr (iAddr),
    .iIn   (iIn),
    .dAddr (dAddr),
    .dIn   (dIn),
    .dOut  (dOut),
    .dOe   (dOe),
    .dWe   (dWe)
  );

  always #10 CLK = ~CLK;  // Period 20

  // Splits the golden image into memories and the expected list
  task automatic loadGolden();
    int i;
    for (i = 0; i < GoldDepth; i++) begin
      golden[i] = Sentinel;
    end
    $readmemh("test/golden_program.txt", golden);
    progLen = 0;
    while (progLen < DataBase && golden[ProgBase + progLen] != Sentinel) begin
      progLen++;
    end
    for (i = 0; i < MemWords; i++) begin
      imem[i] = (i < progLen) ? golden[ProgBase + i] : '0;  // Nops past the end
      dmem[i] = (mipsPkg::wordT'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000; // Per-address fill
    end
    i = DataBase;
    while (i < StoreBase - 1 && golden[i] != Sentinel) begin
      dmem[golden[i][11:2]] = golden[i + 1];
      i += 2;
    end
    i = StoreBase;
    while (i < GoldDepth - 1 && golden[i] != Sentinel) begin
      expAddr.push_back(golden[i]);
      expData.push_back(golden[i + 1]);
      i += 2;
    end
    cycleLimit = 8 * progLen + 200;
  endtask

  // Compares one store against the golden list
  task automatic recordStore(input mipsPkg::wordT addr, input mipsPkg::wordT data);
    if (storeCount < expAddr.size()) begin
      checkStoreAddr(addr, expAddr[storeCount], storeCount);
      checkStoreData(data, expData[storeCount], storeCount);
    end else begin
      errorCount++;
      $display("Unexpected extra store of 0x%08h to 0x%08h at time %0t", data, addr, $time);
    end
    storeCount++;
  endtask

  // One-cycle latency memories
  always @(posedge CLK) begin
    iAddrQ <= iAddr;
    dAddrQ <= dAddr;
    dReadQ <= dOe;
    if (dWe != 4'b0000) begin
      dmem[dAddr[11:2]] <= dOut;
      recordStore(dAddr, dOut);
    end
  end

  // Read data reaches the core half a cycle later
  always @(negedge CLK) begin
    iIn <= imem[iAddrQ[11:2]];
    if (dReadQ) begin
      dIn <= dmem[dAddrQ[11:2]];
    end
  end

  // Run limit
  always @(posedge CLK) begin
    if (running) begin
      cycles++;
      if (cycles >= cycleLimit) begin
        $display("Timeout: program never reached its final store after %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
      end
    end
  end

  initial begin
    CLK        = 1'b0;
    RST_X      = 1'b0;
    STALL      = 1'b0;
    iIn        = '0;
    dIn        = '0;
    storeCount = 0;
    cycles     = 0;
    cycleLimit = 200;
    running    = 1'b0;
    void'($urandom(Seed));
    loadGolden();
    repeat (10) @(negedge CLK);                   // Ten reset cycles
    checkIdlePorts(iAddr, dOe, dWe);
    RST_X   = 1'b1;
    running = 1'b1;
    while (storeCount < expAddr.size()) begin
      @(negedge CLK);
      STALL = ($urandom % 8) == 0;                // About one in eight
    end
    repeat (SettleCycles) begin
      @(negedge CLK);
      STALL = ($urandom % 8) == 0;
    end
    STALL = 1'b0;
    repeat (4) @(negedge CLK);
    checkStoreCount(storeCount, expAddr.size());
    $display("Checks: %0d, errors: %0d, stores: %0d of %0d",
             checkCount, errorCount, storeCount, expAddr.size());
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
